// File: design/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Frame format is 8N1: one start bit, data_bits data bits, one stop bit.
    parameter int data_bits = 8;

    // Width of the bit-timing counters in both serial modules.
    parameter int counter_width = 16;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    // Request decoded from the bus strobes.
    typedef enum logic [1:0] {
        op_none,
        op_write,
        op_read
    } bus_op_t;

endpackage

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  tx_load,
    input  wire [data_bits-1:0]  tx_byte,
    output logic                 tx_busy,
    output logic                 tx_done,
    output logic                 tx
);

    localparam int index_width = $clog2(data_bits);
    localparam logic [counter_width-1:0] bit_last = counter_width'(clks_per_bit - 1);
    localparam logic [index_width-1:0] index_last = index_width'(data_bits - 1);

    tx_state_t                state;
    logic [counter_width-1:0] count;
    logic [index_width-1:0]   bit_index;
    logic [data_bits-1:0]     shift;
    logic                     bit_end;

    assign bit_end = (count == bit_last);
    assign tx_busy = (state != tx_idle);
    assign tx_done = (state == tx_stop) && bit_end; // Last cycle of the stop bit.

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= tx_idle;
            count     <= '0;
            bit_index <= '0;
            tx        <= 1'b1;
        end else if (tx_load) begin
            state     <= tx_start;
            count     <= '0;
            bit_index <= '0;
            tx        <= 1'b0; // Start bit goes out on the next cycle.
        end else begin
            case (state)
                tx_start: begin
                    count <= bit_end ? '0 : count + 1'b1;
                    if (bit_end) begin
                        state <= tx_data;
                        tx    <= shift[0];
                    end
                end
                tx_data: begin
                    count <= bit_end ? '0 : count + 1'b1;
                    if (bit_end) begin
                        if (bit_index == index_last) begin
                            state <= tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                            tx        <= shift[0];
                        end
                    end
                end
                tx_stop: begin
                    count <= bit_end ? '0 : count + 1'b1;
                    if (bit_end) begin
                        state <= tx_idle;
                    end
                end
                default: count <= '0;
            endcase
        end
    end

    // Bit 0 of the shifter always holds the next bit to send.
    always_ff @(posedge clock) begin
        if (tx_load) begin
            shift <= tx_byte;
        end else if (bit_end && (state == tx_start || state == tx_data)) begin
            shift <= shift >> 1;
        end
    end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  rx,
    output logic                 rx_strobe,
    output logic [data_bits-1:0] rx_byte
);

    localparam int index_width = $clog2(data_bits);
    localparam logic [counter_width-1:0] bit_last = counter_width'(clks_per_bit - 1);
    localparam logic [counter_width-1:0] half_last = counter_width'(clks_per_bit / 2 - 1);
    localparam logic [index_width-1:0] index_last = index_width'(data_bits - 1);

    rx_state_t                state;
    logic [counter_width-1:0] count;
    logic [index_width-1:0]   bit_index;
    logic [data_bits-1:0]     shift;
    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_prev;
    logic                     fall;
    logic                     bit_end;

    assign fall      = rx_prev && !rx_sync;
    assign bit_end   = (count == bit_last);
    assign rx_strobe = (state == rx_stop) && bit_end && rx_sync; // Good stop bit only.
    assign rx_byte   = shift;

    // Two-flop synchronizer plus one more stage for edge detection.
    always_ff @(posedge clock) begin
        if (!reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= rx_idle;
            count     <= '0;
            bit_index <= '0;
        end else begin
            case (state)
                rx_idle: begin
                    count     <= '0;
                    bit_index <= '0;
                    if (fall) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (count == half_last) begin
                        count <= '0;
                        // A line that is high again at mid-bit was only a glitch.
                        state <= rx_sync ? rx_idle : rx_data;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                rx_data: begin
                    count <= bit_end ? '0 : count + 1'b1;
                    if (bit_end) begin
                        if (bit_index == index_last) begin
                            state <= rx_stop;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                        end
                    end
                end
                default: begin
                    count <= bit_end ? '0 : count + 1'b1;
                    if (bit_end) begin
                        state <= rx_idle; // Bad stop bits are dropped here too.
                    end
                end
            endcase
        end
    end

    // Data arrives least significant bit first.
    always_ff @(posedge clock) begin
        if (state == rx_data && bit_end) begin
            shift <= {rx_sync, shift[data_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: design/uart_bus.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bus
    import uart_pkg::*;
(
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  valid,
    input  wire [31:0]           wdata,
    input  wire [3:0]            wstrb,
    output logic [31:0]          rdata,
    output logic                 ready,
    output logic                 tx_load,
    output logic [data_bits-1:0] tx_byte,
    input  wire                  tx_busy,
    input  wire                  tx_done,
    input  wire                  rx_strobe,
    input  wire [data_bits-1:0]  rx_byte
);

    bus_op_t              req_op;
    bus_op_t              cur_op;
    logic                 busy;
    logic                 write_go;
    logic                 read_go;
    logic                 finish;
    logic [data_bits-1:0] read_byte;

    always_comb begin
        if (!valid) begin
            req_op = op_none;
        end else if (|wstrb) begin
            req_op = op_write;
        end else begin
            req_op = op_read;
        end
    end

    // A held request is taken once; busy stays set through its ready cycle.
    assign write_go = !busy && (req_op == op_write) && !tx_busy;
    assign read_go  = !busy && (req_op == op_read);

    assign finish = busy && !ready &&
                    (((cur_op == op_write) && tx_done) ||
                     ((cur_op == op_read) && rx_strobe));

    assign tx_load = write_go;
    assign tx_byte = wdata[data_bits-1:0];
    assign rdata   = {{(32 - data_bits){1'b0}}, read_byte};

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy      <= 1'b0;
            cur_op    <= op_none;
            ready     <= 1'b0;
            read_byte <= '0;
        end else begin
            ready <= finish; // Ready lands one cycle after tx_done or rx_strobe.
            if (write_go || read_go) begin
                busy   <= 1'b1;
                cur_op <= req_op;
            end else if (ready) begin
                busy   <= 1'b0;
                cur_op <= op_none;
            end
            if (finish && (cur_op == op_read)) begin
                read_byte <= rx_byte;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top
    import uart_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  wire         clock,
    input  wire         reset,
    input  wire         valid,
    input  wire [31:0]  wdata,
    input  wire [3:0]   wstrb,
    output logic [31:0] rdata,
    output logic        ready,
    input  wire         rx,
    output logic        tx
);

    logic                 tx_load;
    logic [data_bits-1:0] tx_byte;
    logic                 tx_busy;
    logic                 tx_done;
    logic                 rx_strobe;
    logic [data_bits-1:0] rx_byte;

    uart_bus u_bus (
        .clock     (clock),
        .reset     (reset),
        .valid     (valid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .rdata     (rdata),
        .ready     (ready),
        .tx_load   (tx_load),
        .tx_byte   (tx_byte),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_tx (
        .clock   (clock),
        .reset   (reset),
        .tx_load (tx_load),
        .tx_byte (tx_byte),
        .tx_busy (tx_busy),
        .tx_done (tx_done),
        .tx      (tx)
    );

    // The receiver runs freely; bytes with no pending read are lost.
    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_rx (
        .clock     (clock),
        .reset     (reset),
        .rx        (rx),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic reset
);

    localparam time half_period = 4ns; // 8 ns clock period.

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1; // Released after two cycles.
    end

endmodule

`default_nettype wire

// File: dv/uart_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module uart_asserts (
    input wire clock,
    input wire reset,
    input wire valid,
    input wire ready,
    input wire tx,
    input wire tx_load,
    input wire tx_busy
);

    ready_one_cycle: assert property (@(posedge clock) disable iff (!reset)
        ready |=> !ready)
        else $error("ready stayed high for two cycles in a row");

    tx_idle_high: assert property (@(posedge clock) disable iff (!reset)
        !tx_busy |-> tx)
        else $error("tx line is low while the transmitter is idle");

    load_when_free: assert property (@(posedge clock) disable iff (!reset)
        !(tx_load && tx_busy))
        else $error("tx_load was issued while the transmitter was busy");

    ready_needs_valid: assert property (@(posedge clock) disable iff (!reset)
        !valid |-> !ready)
        else $error("ready was high without a request on valid");

endmodule

`default_nettype wire

// File: dv/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tb
    import uart_pkg::*;
();

    localparam int clks_per_bit = 8;
    localparam int write_latency = 10 * clks_per_bit + 2;
    localparam int cycle_limit = 20000; // Well above the frame time of all tests together.

    logic        clock;
    logic        reset;
    logic        valid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] rdata;
    logic        ready;
    logic        rx;
    logic        tx;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rand_state = 32'h8eba_60bf;

    tb_clock u_clock (
        .clock (clock),
        .reset (reset)
    );

    uart_top #(
        .clks_per_bit (clks_per_bit)
    ) dut (
        .clock (clock),
        .reset (reset),
        .valid (valid),
        .wdata (wdata),
        .wstrb (wstrb),
        .rdata (rdata),
        .ready (ready),
        .rx    (rx),
        .tx    (tx)
    );

    bind uart_top uart_asserts u_asserts (
        .clock   (clock),
        .reset   (reset),
        .valid   (valid),
        .ready   (ready),
        .tx      (tx),
        .tx_load (tx_load),
        .tx_busy (tx_busy)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    function logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function logic [7:0] random_byte();
        logic [31:0] value;
        value = lcg_next();
        return value[31:24]; // Upper bits of an LCG are the most random.
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic start_request(input logic [31:0] data, input logic [3:0] strb);
        @(posedge clock);
        #1;
        valid = 1'b1;
        wdata = data;
        wstrb = strb;
    endtask

    task automatic end_request();
        @(posedge clock);
        #1;
        valid = 1'b0;
        wstrb = 4'h0;
    endtask

    // Counts cycles from the drive of the request, that cycle included.
    task automatic wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (ready !== 1'b1);
    endtask

    task automatic drive_rx(input logic level, input int cycles);
        @(posedge clock);
        #1;
        rx = level;
        repeat (cycles - 1) @(posedge clock);
    endtask

    task automatic send_frame(input logic [7:0] value, input logic stop_bit);
        drive_rx(1'b0, clks_per_bit);
        for (int i = 0; i < data_bits; i++) begin
            drive_rx(value[i], clks_per_bit);
        end
        drive_rx(stop_bit, clks_per_bit);
        drive_rx(1'b1, 2 * clks_per_bit); // Idle gap before the next frame.
    endtask

    // Decodes one frame on tx, sampling each bit near its middle.
    task automatic read_tx_frame(output logic [7:0] value);
        value = '0;
        while (tx !== 1'b0) @(negedge clock);
        repeat (clks_per_bit / 2 - 1) @(negedge clock);
        if (tx !== 1'b0) begin
            error_count++;
            $display("Start bit on tx did not last to mid-bit at %0t", $time);
        end
        for (int i = 0; i < data_bits; i++) begin
            repeat (clks_per_bit) @(negedge clock);
            value[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clock);
        if (tx !== 1'b1) begin
            error_count++;
            $display("Stop bit on tx was not high at %0t", $time);
        end
    endtask

    task automatic write_and_check(input logic [31:0] data, input logic [3:0] strb);
        logic [7:0] seen;
        int         cycles;
        fork
            begin
                start_request(data, strb);
                wait_ready(cycles);
            end
            read_tx_frame(seen);
        join
        check_value("ready_latency", 32'(write_latency), 32'(cycles));
        check_value("tx_frame", {24'h0, data[7:0]}, {24'h0, seen});
    endtask

    task automatic test_reset_values();
        @(negedge clock);
        check_value("tx", 32'h1, 32'(tx));
        check_value("ready", 32'h0, 32'(ready));
        check_value("rdata", 32'h0, rdata);
    endtask

    task automatic test_single_write();
        write_and_check(lcg_next(), 4'b0001);
        end_request();
    endtask

    task automatic test_back_to_back_writes();
        logic [31:0] strb_seed;
        strb_seed = lcg_next();
        write_and_check(lcg_next(), 4'b0100);
        write_and_check(lcg_next(), strb_seed[31:28] | 4'b1000); // Issued right after ready.
        end_request();
    endtask

    task automatic test_read();
        logic [7:0]  value;
        logic [31:0] filler;
        int          cycles;
        value = random_byte();
        filler = lcg_next();
        fork
            begin
                start_request(filler, 4'h0);
                wait_ready(cycles);
                end_request();
            end
            begin
                drive_rx(1'b1, 4);
                send_frame(value, 1'b1);
            end
        join
        check_value("rdata", {24'h0, value}, rdata);
    endtask

    // A bad frame or a glitch goes first; only the good frame may end the read.
    task automatic read_after_noise(input bit glitch);
        logic [7:0] bad;
        logic [7:0] good;
        int         cycles;
        int         phase;
        int         phase_at_ready;
        bad = random_byte();
        good = random_byte();
        phase = 0;
        phase_at_ready = 0;
        fork
            begin
                start_request(32'h0, 4'h0);
                wait_ready(cycles);
                phase_at_ready = phase;
                end_request();
            end
            begin
                if (glitch) begin
                    drive_rx(1'b0, 2); // Shorter than half a bit.
                    drive_rx(1'b1, 2 * clks_per_bit);
                end else begin
                    send_frame(bad, 1'b0);
                end
                phase = 1;
                send_frame(good, 1'b1);
            end
        join
        check_value("ready_after_good_frame", 32'h1, 32'(phase_at_ready));
        check_value("rdata", {24'h0, good}, rdata);
    endtask

    initial begin
        valid = 1'b0;
        wdata = 32'h0;
        wstrb = 4'h0;
        rx    = 1'b1;
        wait (reset === 1'b1);
        test_reset_values();
        test_single_write();
        test_back_to_back_writes();
        test_read();
        read_after_noise(1'b0);
        read_after_noise(1'b1);
        repeat (4) @(posedge clock);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_bus.sv
design/uart_top.sv
dv/tb_clock.sv
dv/uart_asserts.sv
dv/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || { echo "Run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
